/* source/pipePkg.sv */
`default_nettype none

package pipePkg;

  // opcode sits in the top nibble of every instruction
  typedef enum logic [3:0] {
    NOP  = 4'd0,
    ADD  = 4'd1,
    SUB  = 4'd2,
    AND  = 4'd3,
    ADDI = 4'd4,
    LDR  = 4'd5,
    STR  = 4'd6,
    B    = 4'd7,
    BZ   = 4'd8
  } opT;

  // eight architectural registers
  typedef logic [2:0] regIdxT;

  typedef logic [15:0] wordT;

  // one instruction word seen through two field layouts
  typedef union packed {
    // register form for add, sub and and
    struct packed {
      opT         op;
      regIdxT     rd;
      regIdxT     rn;
      regIdxT     rm;
      logic [2:0] unused;
    } rType;
    // immediate form, also used by loads, stores and branches
    struct packed {
      opT                op;
      regIdxT            rd;
      regIdxT            rn;
      logic signed [5:0] imm;
    } iType;
  } instrWordT;

  // operand source selects for the execute stage
  localparam logic [1:0] fwdNone = 2'b00;
  localparam logic [1:0] fwdWb   = 2'b01;
  localparam logic [1:0] fwdMem  = 2'b10;

endpackage

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic            clk,
  input  logic            rst,
  input  pipePkg::regIdxT ra1,
  input  pipePkg::regIdxT ra2,
  output pipePkg::wordT   rd1,
  output pipePkg::wordT   rd2,
  input  logic            we,
  input  pipePkg::regIdxT wa,
  input  pipePkg::wordT   wd
);

  pipePkg::wordT regs [0:7];

  // single write port, written at the clock edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
    end
    else if (we)
      regs[wa] <= wd;
  end

  // a register written this cycle reads as its new value,
  // so decode never needs a forward from writeback
  assign rd1 = (we && (wa == ra1)) ? wd : regs[ra1];
  assign rd2 = (we && (wa == ra2)) ? wd : regs[ra2];

endmodule

`default_nettype wire

/* source/hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard (
  input  logic       clk,
  input  logic       rst,
  input  logic       matchAEM, matchAEW, matchBEM, matchBEW,
  input  logic       matchDE,
  input  logic       regWriteM, regWriteW,
  input  logic       memToRegE,
  input  logic       branchTakenE,
  input  logic       dStall,
  output logic [1:0] forwardA, forwardB,
  output logic       stallF, stallD, stallE, stallM,
  output logic       flushD, flushE, flushW
);

  logic ldrStallD;

  // memory stage holds the younger result, so it wins over writeback
  always_comb
  begin
    if (matchAEM && regWriteM)
      forwardA = pipePkg::fwdMem;
    else if (matchAEW && regWriteW)
      forwardA = pipePkg::fwdWb;
    else
      forwardA = pipePkg::fwdNone;

    if (matchBEM && regWriteM)
      forwardB = pipePkg::fwdMem;
    else if (matchBEW && regWriteW)
      forwardB = pipePkg::fwdWb;
    else
      forwardB = pipePkg::fwdNone;
  end

  // load in execute feeding the instruction in decode
  assign ldrStallD = matchDE & memToRegE;

  // load-use holds fetch and decode and sends a bubble into execute
  // data port wait freezes F to M, writeback gets a bubble each cycle
  assign stallF = ldrStallD | dStall;
  assign stallD = ldrStallD | dStall;
  assign stallE = dStall;
  assign stallM = dStall;
  assign flushD = branchTakenE;
  assign flushE = ldrStallD | branchTakenE;
  assign flushW = dStall;

  // stage registers give stall priority, so a flush is only
  // dropped while the whole pipe waits on memory
  assert property (@(posedge clk) disable iff (rst)
    ((stallD && flushD) || (stallE && flushE)) |-> dStall);

  // the spare select code is never produced
  assert property (@(posedge clk) disable iff (rst)
    (forwardA != 2'b11) && (forwardB != 2'b11));

endmodule

`default_nettype wire

/* source/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
  input  logic               clk,
  input  logic               rst,
  input  logic               stallF,
  input  logic               stallD,
  input  logic               flushD,
  input  logic               branchTakenE,
  input  pipePkg::wordT      branchTargetE,
  input  pipePkg::wordT      imemData,
  output pipePkg::wordT      imemAddr,
  output pipePkg::instrWordT instrD,
  output pipePkg::wordT      pcD
);

  pipePkg::wordT pcF;

  // word-addressed pc, one instruction per step
  always_ff @(posedge clk)
  begin
    if (rst)
      pcF <= '0;
    else if (!stallF)
      pcF <= branchTakenE ? branchTargetE : pcF + 16'd1;
  end

  assign imemAddr = pcF;

  // fetch-to-decode register, all zero decodes as nop
  always_ff @(posedge clk)
  begin
    if (rst)
      instrD <= '0;
    else if (!stallD)
      instrD <= flushD ? '0 : imemData;
  end

  // pc of the decode instruction, needed for branch targets
  always_ff @(posedge clk)
  begin
    if (!stallD)
      pcD <= pcF;
  end

endmodule

`default_nettype wire

/* source/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  logic               clk,
  input  logic               rst,
  input  logic               stallE,
  input  logic               flushE,
  input  pipePkg::instrWordT instrD,
  input  pipePkg::wordT      pcD,
  input  pipePkg::wordT      rd1,
  input  pipePkg::wordT      rd2,
  output pipePkg::regIdxT    ra1,
  output pipePkg::regIdxT    ra2,
  output logic               matchDE,
  output pipePkg::regIdxT    rnE, rmE, rdE,
  output pipePkg::wordT      srcAE, srcBE, storeDataE, immE, pcE,
  output pipePkg::opT        opE,
  output logic               regWriteE, memToRegE, memWriteE
);

  pipePkg::opT     opD;
  pipePkg::regIdxT rdD;
  pipePkg::wordT   immD;
  logic            useA, useB;
  logic            regWriteD, memToRegD, memWriteD;

  always_comb
  begin
    // undefined opcodes fall through as nop
    opD       = pipePkg::NOP;
    rdD       = instrD.rType.rd;
    ra1       = instrD.rType.rn;
    ra2       = instrD.rType.rm;
    immD      = '0;
    useA      = 1'b0;
    useB      = 1'b0;
    regWriteD = 1'b0;
    memToRegD = 1'b0;
    memWriteD = 1'b0;
    case (instrD.rType.op)
      pipePkg::ADD, pipePkg::SUB, pipePkg::AND:
      begin
        opD       = instrD.rType.op;
        useA      = 1'b1;
        useB      = 1'b1;
        regWriteD = 1'b1;
      end
      pipePkg::ADDI, pipePkg::LDR, pipePkg::STR, pipePkg::B, pipePkg::BZ:
      begin
        opD  = instrD.iType.op;
        rdD  = instrD.iType.rd;
        ra1  = instrD.iType.rn;
        // store data and the zero test both come from rd
        ra2  = instrD.iType.rd;
        immD = {{10{instrD.iType.imm[5]}}, instrD.iType.imm};
        // these three add rn and the immediate
        useA      = opD inside {pipePkg::ADDI, pipePkg::LDR, pipePkg::STR};
        useB      = opD inside {pipePkg::STR, pipePkg::BZ};
        regWriteD = opD inside {pipePkg::ADDI, pipePkg::LDR};
        memToRegD = (opD == pipePkg::LDR);
        memWriteD = (opD == pipePkg::STR);
      end
      default:
      begin
      end
    endcase
  end

  // raw source match against execute, hazard decides if it is a load
  assign matchDE = (useA && (ra1 == rdE)) || (useB && (ra2 == rdE));

  // control half of the decode-to-execute register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      opE       <= pipePkg::NOP;
      regWriteE <= 1'b0;
      memToRegE <= 1'b0;
      memWriteE <= 1'b0;
    end
    else if (!stallE)
    begin
      opE       <= flushE ? pipePkg::NOP : opD;
      regWriteE <= regWriteD & ~flushE;
      memToRegE <= memToRegD & ~flushE;
      memWriteE <= memWriteD & ~flushE;
    end
  end

  // operand half, srcB already carries the immediate where the alu needs it
  always_ff @(posedge clk)
  begin
    if (!stallE)
    begin
      rnE        <= ra1;
      rmE        <= ra2;
      rdE        <= rdD;
      srcAE      <= rd1;
      srcBE      <= useA ? immD : rd2;
      storeDataE <= rd2;
      immE       <= immD;
      pcE        <= pcD;
    end
  end

  // decode squashes bad opcodes before they leave this stage
  assert property (@(posedge clk) disable iff (rst) opE <= pipePkg::BZ);

endmodule

`default_nettype wire

/* source/execStage.sv */
`timescale 1ns/1ps
`default_nettype none

module execStage (
  input  logic            clk,
  input  logic            rst,
  input  logic            stallM,
  input  pipePkg::regIdxT rnE, rmE, rdE,
  input  pipePkg::wordT   srcAE, srcBE, storeDataE, immE, pcE,
  input  pipePkg::opT     opE,
  input  logic            regWriteE, memToRegE, memWriteE,
  input  logic [1:0]      forwardA, forwardB,
  input  pipePkg::wordT   resultM, resultW,
  input  pipePkg::regIdxT wregW,
  output logic            matchAEM, matchAEW, matchBEM, matchBEW,
  output logic            branchTakenE,
  output pipePkg::wordT   branchTargetE,
  output pipePkg::wordT   aluOutM, storeDataM,
  output pipePkg::regIdxT wregM,
  output logic            regWriteM, memReadM, memWriteM
);

  pipePkg::wordT aE, regBE, aluB, aluOut;
  pipePkg::wordT heldA, heldB;
  logic          holdE;

  assign matchAEM = (rnE == wregM);
  assign matchAEW = (rnE == wregW);
  assign matchBEM = (rmE == wregM);
  assign matchBEW = (rmE == wregW);

  // writeback is flushed during a memory wait, so an operand forwarded
  // from there in the first stalled cycle is kept in heldA/heldB
  always_comb
  begin
    if (forwardA == pipePkg::fwdMem)
      aE = resultM;
    else if (holdE)
      aE = heldA;
    else if (forwardA == pipePkg::fwdWb)
      aE = resultW;
    else
      aE = srcAE;

    if (forwardB == pipePkg::fwdMem)
      regBE = resultM;
    else if (holdE)
      regBE = heldB;
    else if (forwardB == pipePkg::fwdWb)
      regBE = resultW;
    else
      regBE = storeDataE;
  end

  // set while execute still holds last cycle's instruction
  always_ff @(posedge clk)
  begin
    if (rst)
      holdE <= 1'b0;
    else
      holdE <= stallM;
  end

  always_ff @(posedge clk)
  begin
    heldA <= aE;
    heldB <= regBE;
  end

  // addi, ldr and str take the immediate from srcB
  assign aluB = (opE inside {pipePkg::ADDI, pipePkg::LDR, pipePkg::STR}) ? srcBE : regBE;

  always_comb
  begin
    case (opE)
      pipePkg::SUB: aluOut = aE - aluB;
      pipePkg::AND: aluOut = aE & aluB;
      // add, addi and the load/store address
      default:      aluOut = aE + aluB;
    endcase
  end

  // bz tests the forwarded rd value
  assign branchTakenE  = (opE == pipePkg::B) || ((opE == pipePkg::BZ) && (regBE == '0));
  assign branchTargetE = pcE + 16'd1 + immE;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      regWriteM <= 1'b0;
      memReadM  <= 1'b0;
      memWriteM <= 1'b0;
    end
    else if (!stallM)
    begin
      regWriteM <= regWriteE;
      memReadM  <= memToRegE;
      memWriteM <= memWriteE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stallM)
    begin
      aluOutM    <= aluOut;
      storeDataM <= regBE;
      wregM      <= rdE;
    end
  end

endmodule

`default_nettype wire

/* source/memStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memStage #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              stallM,
  input  logic              flushW,
  input  pipePkg::wordT     aluOutM,
  input  pipePkg::wordT     storeDataM,
  input  pipePkg::regIdxT   wregM,
  input  logic              regWriteM, memReadM, memWriteM,
  output logic              wbCyc, wbStb, wbWe,
  output logic [ADDR_W-1:0] wbAdr,
  output pipePkg::wordT     wbDatOut,
  input  pipePkg::wordT     wbDatIn,
  input  logic              wbAck,
  output logic              dStall,
  output pipePkg::wordT     resultM,
  output logic              regWriteW,
  output pipePkg::regIdxT   wregW,
  output pipePkg::wordT     resultW
);

  logic memReqM;
  logic ackSeen;

  assign memReqM = memReadM | memWriteM;

  // an access just finished and the stage moved on
  always_ff @(posedge clk)
  begin
    if (rst)
      ackSeen <= 1'b0;
    else
      ackSeen <= wbAck & ~stallM;
  end

  // cyc and stb drop for one cycle after every ack,
  // even when the next instruction is also a memory access
  assign wbStb    = memReqM & ~ackSeen;
  assign wbCyc    = wbStb;
  assign wbWe     = memWriteM;
  // word address straight from the alu
  assign wbAdr    = aluOutM[ADDR_W-1:0];
  assign wbDatOut = storeDataM;

  // pending access without ack, covers the idle cycle after an ack too
  assign dStall = memReqM & ~wbAck;

  // load data is only valid with ack, which is also when the stage advances
  assign resultM = memReadM ? wbDatIn : aluOutM;

  // memory-to-writeback register
  always_ff @(posedge clk)
  begin
    if (rst || flushW)
      regWriteW <= 1'b0;
    else
      regWriteW <= regWriteM;
  end

  always_ff @(posedge clk)
  begin
    wregW   <= wregM;
    resultW <= resultM;
  end

  // classic bus rule, held through wait states by the stage stall
  assert property (@(posedge clk) disable iff (rst)
    (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbDatOut)));

endmodule

`default_nettype wire

/* source/pipeCore.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCore #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst,
  output pipePkg::wordT     imemAddr,
  input  pipePkg::wordT     imemData,
  output logic              wbCyc, wbStb, wbWe,
  output logic [ADDR_W-1:0] wbAdr,
  output pipePkg::wordT     wbDatOut,
  input  pipePkg::wordT     wbDatIn,
  input  logic              wbAck
);

  // hazard control
  logic       stallF, stallD, stallE, stallM;
  logic       flushD, flushE, flushW;
  logic [1:0] forwardA, forwardB;
  logic       matchAEM, matchAEW, matchBEM, matchBEW, matchDE;
  logic       dStall;

  // fetch to decode
  pipePkg::instrWordT instrD;
  pipePkg::wordT      pcD;

  // register file read side
  pipePkg::regIdxT ra1, ra2;
  pipePkg::wordT   rd1, rd2;

  // execute stage
  pipePkg::regIdxT rnE, rmE, rdE;
  pipePkg::wordT   srcAE, srcBE, storeDataE, immE, pcE;
  pipePkg::opT     opE;
  logic            regWriteE, memToRegE, memWriteE;
  logic            branchTakenE;
  pipePkg::wordT   branchTargetE;

  // memory stage
  pipePkg::wordT   aluOutM, storeDataM, resultM;
  pipePkg::regIdxT wregM;
  logic            regWriteM, memReadM, memWriteM;

  // writeback, also the register file write port
  pipePkg::wordT   resultW;
  pipePkg::regIdxT wregW;
  logic            regWriteW;

  regFile regFileI (
    .clk, .rst, .ra1, .ra2, .rd1, .rd2,
    .we(regWriteW),
    .wa(wregW),
    .wd(resultW)
  );

  hazard hazardI (.*);

  fetchUnit fetchI (.*);

  decodeStage decodeI (.*);

  execStage execI (.*);

  // only this stage sees the bus address width
  memStage #(
    .ADDR_W(ADDR_W)
  ) memI (.*);

endmodule

`default_nettype wire

/* verif/dataRam.sv */
`timescale 1ns/1ps
`default_nettype none

module dataRam #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cyc,
  input  logic              stb,
  input  logic              we,
  input  logic [ADDR_W-1:0] adr,
  input  logic [15:0]       datW,
  output logic [15:0]       datR,
  output logic              ack
);

  localparam int words = 1 << ADDR_W;

  logic [15:0] mem [0:words-1];
  logic [7:0]  lfsr, lfsrOne, lfsrTwo;
  logic [1:0]  waitTarget;
  logic [1:0]  waitCnt;

  // store log, read back by the testbench
  logic [ADDR_W-1:0] logAdr [0:63];
  logic [15:0]       logDat [0:63];
  int                logCount;
  logic              markerSeen;

  // galois lfsr, taps 8 6 5 4
  function automatic logic [7:0] lfsrStep(input logic [7:0] s);
    lfsrStep = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  // one step per bit, two bits give 0 to 3 wait states
  assign lfsrOne    = lfsrStep(lfsr);
  assign lfsrTwo    = lfsrStep(lfsrOne);
  assign waitTarget = {lfsrOne[0], lfsr[0]};

  // ack once the drawn number of wait states has passed
  assign ack  = cyc && stb && (waitCnt == waitTarget);
  assign datR = mem[adr];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lfsr       <= 8'd86;
      waitCnt    <= '0;
      logCount   <= 0;
      markerSeen <= 1'b0;
      // fill value mixes every address bit
      for (int i = 0; i < words; i++)
        mem[i] <= 16'(i * 263) ^ 16'h5A3C;
    end
    else if (cyc && stb)
    begin
      if (ack)
      begin
        waitCnt <= '0;
        // fresh wait count for the next access
        lfsr    <= lfsrTwo;
        if (we)
        begin
          mem[adr] <= datW;
          if (logCount < 64)
          begin
            logAdr[logCount] <= adr;
            logDat[logCount] <= datW;
            logCount         <= logCount + 1;
          end
          // top address ends a program
          if (adr == '1)
            markerSeen <= 1'b1;
        end
      end
      else
        waitCnt <= waitCnt + 2'd1;
    end
  end

endmodule

`default_nettype wire

/* verif/tbPipeCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbPipeCore;

  localparam int addrW    = 8;
  localparam int memWords = 1 << addrW;
  localparam int romWords = 64;
  localparam int numTests = 5;
  // per program budget covers reset, stalls and wait states
  localparam int cycleLimit = 300 * numTests;

  logic             clk;
  logic             rst;
  pipePkg::wordT    imemAddr;
  pipePkg::wordT    imemData;
  logic             wbCyc, wbStb, wbWe, wbAck;
  logic [addrW-1:0] wbAdr;
  pipePkg::wordT    wbDatOut, wbDatIn;

  // program rom, reads past the end give nop
  logic [15:0] prog [0:romWords-1];
  int          progLen;

  // stores predicted by the reference interpreter
  logic [15:0] expAdr [0:63];
  logic [15:0] expDat [0:63];
  int          expCount;

  int cycleCount = 0;
  int errorCount = 0;

  assign imemData = (imemAddr < romWords) ? prog[imemAddr[5:0]] : 16'h0000;

  pipeCore #(
    .ADDR_W(addrW)
  ) dut_i (
    .clk, .rst, .imemAddr, .imemData,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatOut, .wbDatIn, .wbAck
  );

  dataRam #(
    .ADDR_W(addrW)
  ) ram_i (
    .clk, .rst,
    .cyc(wbCyc),
    .stb(wbStb),
    .we(wbWe),
    .adr(wbAdr),
    .datW(wbDatOut),
    .datR(wbDatIn),
    .ack(wbAck)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout after %0d cycles, a program never reached its marker store",
               cycleCount);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  end

  task automatic failNow(input string msg);
    errorCount++;
    $display("ERROR %0t ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // instruction encoders, op rd rn rm and op rd rn imm6
  function automatic logic [15:0] rForm(input logic [3:0] op, input int rd, rn, rm);
    rForm = {op, 3'(rd), 3'(rn), 3'(rm), 3'b000};
  endfunction

  function automatic logic [15:0] iForm(input logic [3:0] op, input int rd, rn, imm);
    iForm = {op, 3'(rd), 3'(rn), 6'(imm)};
  endfunction

  task automatic emit(input logic [15:0] w);
    if (progLen >= romWords)
      failNow("program does not fit in the rom");
    prog[progLen] = w;
    progLen++;
  endtask

  // marker store to the top address, then spin in place
  task automatic endProgram(input int dataReg, input int scratch);
    emit(iForm(pipePkg::ADDI, scratch, 0, -1));
    emit(iForm(pipePkg::STR, dataReg, scratch, 0));
    emit(iForm(pipePkg::B, 0, 0, -1));
  endtask

  // instruction set model, one instruction per step
  task automatic refRun(input string name);
    logic [15:0] regs [0:7];
    logic [15:0] mem [0:memWords-1];
    logic [15:0] ins, imm, adr, pc;
    logic [3:0]  op;
    logic [2:0]  rd, rn, rm;
    int          steps;
    logic        done;
    for (int i = 0; i < 8; i++)
      regs[i] = '0;
    for (int i = 0; i < memWords; i++)
      mem[i] = 16'(i * 263) ^ 16'h5A3C;
    pc       = '0;
    steps    = 0;
    done     = 1'b0;
    expCount = 0;
    while (!done && steps < 2000)
    begin
      ins   = (pc < romWords) ? prog[pc[5:0]] : 16'h0000;
      op    = ins[15:12];
      rd    = ins[11:9];
      rn    = ins[8:6];
      rm    = ins[5:3];
      imm   = {{10{ins[5]}}, ins[5:0]};
      adr   = (regs[rn] + imm) & 16'(memWords - 1);
      pc    = pc + 16'd1;
      steps = steps + 1;
      case (op)
        pipePkg::ADD:  regs[rd] = regs[rn] + regs[rm];
        pipePkg::SUB:  regs[rd] = regs[rn] - regs[rm];
        pipePkg::AND:  regs[rd] = regs[rn] & regs[rm];
        pipePkg::ADDI: regs[rd] = regs[rn] + imm;
        pipePkg::LDR:  regs[rd] = mem[adr];
        pipePkg::STR:
        begin
          mem[adr]         = regs[rd];
          expAdr[expCount] = adr;
          expDat[expCount] = regs[rd];
          expCount         = expCount + 1;
          done             = (adr == 16'(memWords - 1));
        end
        // pc already points past the branch
        pipePkg::B:    pc = pc + imm;
        pipePkg::BZ:
        begin
          if (regs[rd] == 16'h0000)
            pc = pc + imm;
        end
        default:
        begin
        end
      endcase
    end
    if (!done)
      failNow($sformatf("%s: reference run never reached the marker store", name));
  endtask

  // bus idle until instruction firstMem arrives in memory, three cycles after fetch
  task automatic checkBusQuiet(input int firstMem);
    for (int j = 0; j <= firstMem + 3; j++)
    begin
      @(negedge clk);
      if (j < firstMem + 3)
        assert (!wbCyc && !wbStb)
        else failNow($sformatf("bus active in cycle %0d, before the first load or store", j));
      else
        assert (wbCyc && wbStb)
        else failNow("first store did not start a bus cycle in the memory stage");
    end
  endtask

  task automatic compareStores(input string name);
    assert (ram_i.logCount == expCount)
    else failNow($sformatf("%s: %0d stores seen, %0d expected",
                           name, ram_i.logCount, expCount));
    for (int i = 0; i < expCount; i++)
    begin
      assert ((16'(ram_i.logAdr[i]) == expAdr[i]) && (ram_i.logDat[i] == expDat[i]))
      else failNow($sformatf("%s: store %0d wrote %h to %h, expected %h to %h", name, i,
                             ram_i.logDat[i], ram_i.logAdr[i], expDat[i], expAdr[i]));
    end
  endtask

  // hold reset while a new program goes into the rom
  task automatic startProgram();
    @(posedge clk);
    #1;
    rst = 1'b1;
    for (int i = 0; i < romWords; i++)
      prog[i] = 16'h0000;
    progLen = 0;
  endtask

  task automatic runProgram(input string name, input int firstMem);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    refRun(name);
    if (firstMem >= 0)
      checkBusQuiet(firstMem);
    while (!ram_i.markerSeen)
      @(negedge clk);
    // a few loop turns show up any store from a flushed slot
    repeat (12) @(negedge clk);
    compareStores(name);
    $display("%s: %0d stores checked", name, expCount);
  endtask

  // dependent alu ops back to back, forwards from memory and writeback
  task automatic testAluChain();
    startProgram();
    emit(iForm(pipePkg::ADDI, 1, 0, 5));
    emit(iForm(pipePkg::ADDI, 2, 1, 3));
    emit(rForm(pipePkg::ADD, 3, 1, 2));
    emit(rForm(pipePkg::SUB, 4, 3, 1));
    emit(rForm(pipePkg::AND, 5, 4, 3));
    emit(iForm(pipePkg::ADDI, 6, 5, -7));
    emit(rForm(pipePkg::SUB, 7, 6, 3));
    emit(iForm(pipePkg::STR, 7, 0, 0));
    emit(iForm(pipePkg::STR, 6, 0, 1));
    emit(rForm(pipePkg::ADD, 1, 7, 6));
    emit(iForm(pipePkg::STR, 1, 0, 2));
    emit(rForm(pipePkg::AND, 2, 1, 4));
    emit(iForm(pipePkg::STR, 2, 0, 3));
    emit(iForm(pipePkg::ADDI, 3, 3, 31));
    emit(iForm(pipePkg::STR, 3, 0, 4));
    endProgram(5, 6);
    runProgram("aluChain", 7);
  endtask

  // each load feeds the next instruction
  task automatic testLoadUse();
    startProgram();
    emit(iForm(pipePkg::ADDI, 1, 0, 10));
    emit(iForm(pipePkg::LDR, 2, 1, 0));
    emit(rForm(pipePkg::ADD, 3, 2, 1));
    emit(iForm(pipePkg::STR, 3, 0, 20));
    emit(iForm(pipePkg::LDR, 4, 1, 1));
    emit(iForm(pipePkg::ADDI, 5, 4, 1));
    emit(iForm(pipePkg::STR, 5, 0, 21));
    emit(iForm(pipePkg::LDR, 6, 1, 2));
    emit(iForm(pipePkg::STR, 6, 0, 22));
    emit(iForm(pipePkg::LDR, 7, 1, 3));
    emit(rForm(pipePkg::SUB, 3, 1, 7));
    emit(iForm(pipePkg::STR, 3, 0, 23));
    emit(iForm(pipePkg::STR, 3, 0, 24));
    emit(iForm(pipePkg::LDR, 4, 0, 24));
    emit(rForm(pipePkg::AND, 5, 4, 2));
    emit(iForm(pipePkg::STR, 5, 0, 25));
    endProgram(4, 6);
    runProgram("loadUse", -1);
  endtask

  // stores sit in the slots behind each taken branch
  task automatic testBranches();
    startProgram();
    emit(iForm(pipePkg::ADDI, 1, 0, 1));
    emit(iForm(pipePkg::B, 0, 0, 2));
    emit(iForm(pipePkg::ADDI, 1, 1, 16));
    emit(iForm(pipePkg::STR, 1, 0, 10));
    emit(iForm(pipePkg::ADDI, 2, 0, 0));
    emit(iForm(pipePkg::BZ, 2, 0, 2));
    emit(iForm(pipePkg::STR, 1, 0, 11));
    emit(iForm(pipePkg::ADDI, 1, 1, 8));
    emit(iForm(pipePkg::BZ, 1, 0, 2));
    emit(iForm(pipePkg::ADDI, 3, 1, 2));
    emit(iForm(pipePkg::STR, 3, 0, 12));
    emit(iForm(pipePkg::ADDI, 4, 0, 3));
    // countdown loop, bz tests the value just computed
    emit(iForm(pipePkg::ADDI, 4, 4, -1));
    emit(iForm(pipePkg::BZ, 4, 0, 2));
    emit(iForm(pipePkg::STR, 4, 0, 14));
    emit(iForm(pipePkg::B, 0, 0, -4));
    emit(iForm(pipePkg::STR, 4, 0, 13));
    endProgram(3, 5);
    runProgram("branches", -1);
  endtask

  // back to back loads and stores, sums show lost or doubled writes
  task automatic testWaitStores();
    startProgram();
    emit(iForm(pipePkg::ADDI, 7, 0, 25));
    emit(iForm(pipePkg::ADDI, 7, 7, 25));
    emit(iForm(pipePkg::ADDI, 1, 0, 1));
    emit(iForm(pipePkg::STR, 1, 7, 0));
    emit(rForm(pipePkg::ADD, 1, 1, 1));
    emit(iForm(pipePkg::STR, 1, 7, 1));
    emit(rForm(pipePkg::ADD, 1, 1, 1));
    emit(iForm(pipePkg::STR, 1, 7, 2));
    emit(iForm(pipePkg::LDR, 2, 7, 1));
    emit(rForm(pipePkg::ADD, 2, 2, 1));
    emit(iForm(pipePkg::STR, 2, 7, 3));
    emit(iForm(pipePkg::ADDI, 3, 2, 5));
    emit(iForm(pipePkg::STR, 3, 7, 4));
    emit(iForm(pipePkg::LDR, 4, 7, 4));
    emit(iForm(pipePkg::STR, 4, 7, 5));
    emit(rForm(pipePkg::ADD, 5, 4, 3));
    emit(iForm(pipePkg::STR, 5, 7, 6));
    endProgram(5, 6);
    runProgram("waitStores", -1);
  endtask

  // running sum over eight loaded words
  task automatic testLoadLoop();
    startProgram();
    emit(iForm(pipePkg::ADDI, 1, 0, 8));
    emit(iForm(pipePkg::ADDI, 2, 0, 0));
    emit(iForm(pipePkg::ADDI, 3, 0, 0));
    emit(iForm(pipePkg::LDR, 4, 3, 0));
    emit(rForm(pipePkg::ADD, 2, 2, 4));
    emit(iForm(pipePkg::STR, 2, 3, 31));
    emit(iForm(pipePkg::ADDI, 3, 3, 1));
    emit(iForm(pipePkg::ADDI, 1, 1, -1));
    emit(iForm(pipePkg::BZ, 1, 0, 1));
    emit(iForm(pipePkg::B, 0, 0, -7));
    endProgram(2, 5);
    runProgram("loadLoop", -1);
  endtask

  initial
  begin
    rst      = 1'b1;
    progLen  = 0;
    expCount = 0;
    for (int i = 0; i < romWords; i++)
      prog[i] = 16'h0000;
    testAluChain();
    testLoadUse();
    testBranches();
    testWaitStores();
    testLoadLoop();
    if (errorCount == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("STATUS: FAIL");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* sim.f */
source/pipePkg.sv
source/regFile.sv
source/hazard.sv
source/fetchUnit.sv
source/decodeStage.sv
source/execStage.sv
source/memStage.sv
source/pipeCore.sv
verif/dataRam.sv
verif/tbPipeCore.sv
